// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  // register port widths
  localparam int DATA_W = 8;
  localparam int ADDR_W = 3;
  // dip switch count on the gpio port
  localparam int DIP_W = 4;

  // register address map
  localparam logic [ADDR_W-1:0] ADDR_LED       = 3'd0;
  localparam logic [ADDR_W-1:0] ADDR_DIP       = 3'd1;
  localparam logic [ADDR_W-1:0] ADDR_UART_DATA = 3'd2;
  localparam logic [ADDR_W-1:0] ADDR_UART_DIV  = 3'd3;
  localparam logic [ADDR_W-1:0] ADDR_SPI_DATA  = 3'd4;
  localparam logic [ADDR_W-1:0] ADDR_SPI_CTRL  = 3'd5;
  localparam logic [ADDR_W-1:0] ADDR_STATUS    = 3'd6;

  // divisor values after reset
  localparam logic [DATA_W-1:0] UART_DIV_RST = 8'd4;
  localparam logic [6:0]        SPI_DIV_RST  = 7'd2;

  // one register access from the on-chip master, 13 bits
  typedef struct packed {
    logic              we;
    logic              re;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  // spi control register layout
  typedef struct packed {
    // chip select level, active low
    logic       cs_n;
    // sclk half period in clk cycles
    logic [6:0] div;
  } spi_ctrl_t;

  // status word, msb first
  typedef struct packed {
    logic       uart_busy;
    logic       spi_busy;
    logic       sd_detect;
    logic       sd_protect;
    logic [3:0] spare;
  } status_t;

endpackage

`default_nettype wire

// ==== periph_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module periph_decode (
  input  wire logic                      clk,
  input  wire logic                      i_rst_n,
  input  wire soc_pkg::reg_req_t         i_req,
  input  wire logic [soc_pkg::DIP_W-1:0] i_dip,
  input  wire logic                      i_sd_detect,
  input  wire logic                      i_sd_protect,
  input  wire logic                      i_uart_busy,
  input  wire logic                      i_spi_busy,
  input  wire logic [soc_pkg::DATA_W-1:0] i_spi_rx,
  output logic                           o_led_we,
  output logic                           o_uart_start,
  output logic [soc_pkg::DATA_W-1:0]     o_uart_div,
  output logic                           o_spi_start,
  output soc_pkg::spi_ctrl_t             o_spi_ctrl,
  output logic [soc_pkg::DATA_W-1:0]     o_wdata,
  output logic [soc_pkg::DATA_W-1:0]     o_rdata
);
  import soc_pkg::*;

  status_t           status;
  logic [DATA_W-1:0] rd_mux;

  // write strobes, one per request cycle
  assign o_led_we     = i_req.we && (i_req.addr == ADDR_LED);
  assign o_uart_start = i_req.we && (i_req.addr == ADDR_UART_DATA);
  assign o_spi_start  = i_req.we && (i_req.addr == ADDR_SPI_DATA);
  // write data shared by all peripherals
  assign o_wdata      = i_req.wdata;

  // divisor and control registers
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_uart_div      <= UART_DIV_RST;
      o_spi_ctrl.cs_n <= 1'b1;
      o_spi_ctrl.div  <= SPI_DIV_RST;
    end else if (i_req.we) begin
      if (i_req.addr == ADDR_UART_DIV) begin
        o_uart_div <= i_req.wdata;
      end
      if (i_req.addr == ADDR_SPI_CTRL) begin
        o_spi_ctrl <= spi_ctrl_t'(i_req.wdata);
      end
    end
  end

  // status word from busy levels and synced card pins
  always_comb begin
    status            = '0;
    status.uart_busy  = i_uart_busy;
    status.spi_busy   = i_spi_busy;
    status.sd_detect  = i_sd_detect;
    status.sd_protect = i_sd_protect;
  end

  // read select, led and uart data are write only
  always_comb begin
    case (i_req.addr)
      ADDR_DIP:      rd_mux = {{(DATA_W-DIP_W){1'b0}}, i_dip};
      ADDR_UART_DIV: rd_mux = o_uart_div;
      ADDR_SPI_DATA: rd_mux = i_spi_rx;
      ADDR_SPI_CTRL: rd_mux = o_spi_ctrl;
      ADDR_STATUS:   rd_mux = status;
      default:       rd_mux = '0;
    endcase
  end

  // read data one cycle after the strobe, held until the next read
  always_ff @(posedge clk) begin
    if (i_req.re) begin
      o_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== gpio_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpio_port (
  input  wire logic                       clk,
  input  wire logic                       i_rst_n,
  input  wire logic                       i_led_we,
  input  wire logic [soc_pkg::DATA_W-1:0] i_wdata,
  input  wire logic [soc_pkg::DIP_W-1:0]  i_dip_pins,
  input  wire logic                       i_sd_detect_pin,
  input  wire logic                       i_sd_protect_pin,
  output logic [soc_pkg::DATA_W-1:0]      o_led,
  output logic [soc_pkg::DIP_W-1:0]       o_dip,
  output logic                            o_sd_detect,
  output logic                            o_sd_protect
);
  import soc_pkg::*;

  // board inputs grouped as one word: dip, detect, protect
  logic [DIP_W+1:0] sync_q1;
  logic [DIP_W+1:0] sync_q2;

  // led register, cleared at reset
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_led <= '0;
    end else if (i_led_we) begin
      o_led <= i_wdata;
    end
  end

  // two-stage synchronizer for asynchronous switches
  always_ff @(posedge clk) begin
    sync_q1 <= {i_dip_pins, i_sd_detect_pin, i_sd_protect_pin};
    sync_q2 <= sync_q1;
  end

  assign o_dip        = sync_q2[DIP_W+1:2];
  assign o_sd_detect  = sync_q2[1];
  assign o_sd_protect = sync_q2[0];

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
  input  wire logic                       clk,
  input  wire logic                       i_rst_n,
  input  wire logic                       i_start,
  input  wire logic [soc_pkg::DATA_W-1:0] i_data,
  input  wire logic [soc_pkg::DATA_W-1:0] i_div,
  output logic                            o_busy,
  output logic                            o_td
);
  import soc_pkg::*;

  // frame = stop, data msb..lsb, start; bit 0 goes out first
  logic [DATA_W+1:0] frame_q;
  // divisor latched per frame
  logic [DATA_W-1:0] div_q;
  // cycles spent in the current bit
  logic [DATA_W-1:0] div_cnt;
  // bit index 0..9
  logic [3:0]        bit_cnt;
  logic              bit_end;

  assign bit_end = (div_cnt == div_q - 1'b1);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      // all ones keeps the line idle high
      frame_q <= '1;
      div_q   <= UART_DIV_RST;
      div_cnt <= '0;
      bit_cnt <= '0;
      o_busy  <= 1'b0;
    end else if (!o_busy) begin
      // start while busy falls through and is dropped
      if (i_start) begin
        frame_q <= {1'b1, i_data, 1'b0};
        div_q   <= i_div;
        div_cnt <= '0;
        bit_cnt <= '0;
        o_busy  <= 1'b1;
      end
    end else if (bit_end) begin
      div_cnt <= '0;
      // shift in ones so the line returns high
      frame_q <= {1'b1, frame_q[DATA_W+1:1]};
      if (bit_cnt == 4'd9) begin
        // stop bit done
        o_busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // line driven straight from the frame register
  assign o_td = frame_q[0];

endmodule

`default_nettype wire

// ==== spi_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_master (
  input  wire logic                       clk,
  input  wire logic                       i_rst_n,
  input  wire logic                       i_start,
  input  wire logic [soc_pkg::DATA_W-1:0] i_data,
  input  wire soc_pkg::spi_ctrl_t         i_ctrl,
  input  wire logic                       i_miso,
  output logic                            o_busy,
  output logic [soc_pkg::DATA_W-1:0]      o_rx,
  output logic                            o_cs_n,
  output logic                            o_sclk,
  output logic                            o_mosi
);
  import soc_pkg::*;

  // tx bits leave at the top, rx bits enter at the bottom
  logic [DATA_W-1:0] shreg;
  // half period latched at start
  logic [6:0]        div_q;
  logic [6:0]        half_cnt;
  logic [2:0]        bit_cnt;
  // miso captured on the rising sclk edge
  logic              miso_q;
  logic              half_end;

  assign half_end = (half_cnt == div_q - 7'd1);

  // chip select follows the control register only
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_cs_n <= 1'b1;
    end else begin
      o_cs_n <= i_ctrl.cs_n;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      shreg    <= '0;
      div_q    <= SPI_DIV_RST;
      half_cnt <= '0;
      bit_cnt  <= '0;
      miso_q   <= 1'b0;
      o_sclk   <= 1'b0;
      o_busy   <= 1'b0;
    end else if (!o_busy) begin
      // idle: sclk low, start accepted only here
      if (i_start) begin
        shreg    <= i_data;
        div_q    <= i_ctrl.div;
        half_cnt <= '0;
        bit_cnt  <= '0;
        o_sclk   <= 1'b0;
        o_busy   <= 1'b1;
      end
    end else if (!half_end) begin
      half_cnt <= half_cnt + 7'd1;
    end else if (!o_sclk) begin
      // low half done, rising edge
      half_cnt <= '0;
      o_sclk   <= 1'b1;
      miso_q   <= i_miso;
    end else begin
      // high half done, falling edge moves the next mosi bit out
      half_cnt <= '0;
      o_sclk   <= 1'b0;
      shreg    <= {shreg[DATA_W-2:0], miso_q};
      if (bit_cnt == 3'd7) begin
        o_busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  // msb first
  assign o_mosi = shreg[DATA_W-1];
  // full received byte once busy drops
  assign o_rx   = shreg;

endmodule

`default_nettype wire

// ==== periph_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module periph_top (
  input  wire logic                       clk,
  input  wire logic                       i_rst_n,
  input  wire soc_pkg::reg_req_t          i_req,
  input  wire logic [soc_pkg::DIP_W-1:0]  i_dip_pins,
  input  wire logic                       i_sd_detect,
  input  wire logic                       i_sd_protect,
  input  wire logic                       i_spi_miso,
  output logic [soc_pkg::DATA_W-1:0]      o_rdata,
  output logic [soc_pkg::DATA_W-1:0]      o_led,
  output logic                            o_uart_td,
  output logic                            o_spi_cs_n,
  output logic                            o_spi_sclk,
  output logic                            o_spi_mosi
);
  import soc_pkg::*;

  // decoder to peripherals
  logic              led_we;
  logic              uart_start;
  logic              spi_start;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] uart_div;
  spi_ctrl_t         spi_ctrl;
  // peripherals back to decoder
  logic [DIP_W-1:0]  dip_sync;
  logic              sd_detect_sync;
  logic              sd_protect_sync;
  logic              uart_busy;
  logic              spi_busy;
  logic [DATA_W-1:0] spi_rx;

  periph_decode u_decode (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_req        (i_req),
    .i_dip        (dip_sync),
    .i_sd_detect  (sd_detect_sync),
    .i_sd_protect (sd_protect_sync),
    .i_uart_busy  (uart_busy),
    .i_spi_busy   (spi_busy),
    .i_spi_rx     (spi_rx),
    .o_led_we     (led_we),
    .o_uart_start (uart_start),
    .o_uart_div   (uart_div),
    .o_spi_start  (spi_start),
    .o_spi_ctrl   (spi_ctrl),
    .o_wdata      (wdata),
    .o_rdata      (o_rdata)
  );

  // leds and board switches
  gpio_port u_gpio (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_led_we         (led_we),
    .i_wdata          (wdata),
    .i_dip_pins       (i_dip_pins),
    .i_sd_detect_pin  (i_sd_detect),
    .i_sd_protect_pin (i_sd_protect),
    .o_led            (o_led),
    .o_dip            (dip_sync),
    .o_sd_detect      (sd_detect_sync),
    .o_sd_protect     (sd_protect_sync)
  );

  // console line
  uart_tx u_uart_tx (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_start (uart_start),
    .i_data  (wdata),
    .i_div   (uart_div),
    .o_busy  (uart_busy),
    .o_td    (o_uart_td)
  );

  // sd card spi
  spi_master u_spi (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_start (spi_start),
    .i_data  (wdata),
    .i_ctrl  (spi_ctrl),
    .i_miso  (i_spi_miso),
    .o_busy  (spi_busy),
    .o_rx    (spi_rx),
    .o_cs_n  (o_spi_cs_n),
    .o_sclk  (o_spi_sclk),
    .o_mosi  (o_spi_mosi)
  );

endmodule

`default_nettype wire

// ==== periph_top_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module periph_top_chk (
  input wire logic clk,
  input wire logic i_rst_n,
  input wire logic i_uart_td,
  input wire logic i_spi_cs_n,
  input wire logic i_spi_sclk,
  input wire logic i_spi_mosi
);

  // no clock to the card while it is deselected
  sclk_low_when_deselected: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_spi_cs_n |-> !i_spi_sclk
  ) else $error("spi sclk high while chip select is high");

  // console line idles high during reset
  uart_idle_in_reset: assert property (
    @(posedge clk)
    !i_rst_n |=> i_uart_td
  ) else $error("uart line not high while reset is active");

  // mosi only moves on the falling sclk edge, never with the rising one
  mosi_stable_while_sclk_high: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_spi_sclk |-> $stable(i_spi_mosi)
  ) else $error("spi mosi changed while sclk was high");

endmodule

`default_nettype wire

// ==== tb_periph_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_periph_top;
  import soc_pkg::*;

  logic              clk;
  logic              i_rst_n;
  reg_req_t          i_req;
  logic [DIP_W-1:0]  i_dip_pins;
  logic              i_sd_detect;
  logic              i_sd_protect;
  logic              i_spi_miso;
  logic [DATA_W-1:0] o_rdata;
  logic [DATA_W-1:0] o_led;
  logic              o_uart_td;
  logic              o_spi_cs_n;
  logic              o_spi_sclk;
  logic              o_spi_mosi;

  // one word per operation: op, a, b, c
  logic [31:0]       stim [0:63];
  // what software last wrote or set
  logic [DATA_W-1:0] uart_div_model;
  logic              detect_model;
  logic              protect_model;
  logic [31:0]       lcg_state;
  int                budget_cycles;
  string             cur_test;

  periph_top uut (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_req        (i_req),
    .i_dip_pins   (i_dip_pins),
    .i_sd_detect  (i_sd_detect),
    .i_sd_protect (i_sd_protect),
    .i_spi_miso   (i_spi_miso),
    .o_rdata      (o_rdata),
    .o_led        (o_led),
    .o_uart_td    (o_uart_td),
    .o_spi_cs_n   (o_spi_cs_n),
    .o_spi_sclk   (o_spi_sclk),
    .o_spi_mosi   (o_spi_mosi)
  );

  // pin protocol checks inside the dut
  bind periph_top periph_top_chk u_chk (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_uart_td  (o_uart_td),
    .i_spi_cs_n (o_spi_cs_n),
    .i_spi_sclk (o_spi_sclk),
    .i_spi_mosi (o_spi_mosi)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "status mismatch");
    end
  endtask

  // single pin levels
  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s expected %b actual %b", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "pin mismatch");
    end
  endtask

  // status word as the pins and busy units should show it
  function automatic status_t expect_status(input logic uart_busy, input logic spi_busy);
    status_t st;
    st            = '0;
    st.uart_busy  = uart_busy;
    st.spi_busy   = spi_busy;
    st.sd_detect  = detect_model;
    st.sd_protect = protect_model;
    return st;
  endfunction

  // lcg step, top byte is best mixed
  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  // cycles the stimulus needs, frame lengths included
  function automatic int frame_budget();
    int          cycles;
    int          udiv;
    int          sdiv;
    logic [31:0] word;
    cycles = 500;
    udiv   = UART_DIV_RST;
    sdiv   = SPI_DIV_RST;
    for (int i = 0; i < $size(stim); i++) begin
      word = stim[i];
      if ($isunknown(word) || word[31:24] == 8'h00) break;
      cycles += 40;
      if (word[31:24] == 8'h01 && word[23:16] == ADDR_UART_DIV) udiv = word[15:8];
      if (word[31:24] == 8'h01 && word[23:16] == ADDR_SPI_CTRL) sdiv = word[14:8];
      if (word[31:24] == 8'h04 || (word[31:24] == 8'h06 && word[7:0] == 8'h01)) begin
        cycles += 11 * udiv;
      end
      if (word[31:24] == 8'h05 || (word[31:24] == 8'h06 && word[7:0] == 8'h02)) begin
        cycles += 16 * sdiv;
      end
    end
    return cycles;
  endfunction

  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    i_req.we    = 1'b1;
    i_req.re    = 1'b0;
    i_req.addr  = addr;
    i_req.wdata = data;
    @(negedge clk);
    i_req = '0;
  endtask

  // rdata is captured at the edge after the strobe
  task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(negedge clk);
    i_req.we    = 1'b0;
    i_req.re    = 1'b1;
    i_req.addr  = addr;
    i_req.wdata = '0;
    @(negedge clk);
    i_req = '0;
    data  = o_rdata;
  endtask

  // two sync stages before a read sees the pins
  task automatic set_pins(input logic [DIP_W-1:0] dip, input logic det, input logic prot);
    @(negedge clk);
    i_dip_pins    = dip;
    i_sd_detect   = det;
    i_sd_protect  = prot;
    detect_model  = det;
    protect_model = prot;
    repeat (2) @(negedge clk);
  endtask

  // line monitor, samples at mid bit on falling clk edges
  task automatic watch_uart_line(output logic [7:0] data);
    @(negedge o_uart_td);
    repeat (uart_div_model / 2 + 1) @(negedge clk);
    if (o_uart_td !== 1'b0) fail_run("uart start bit was not low at mid bit");
    for (int i = 0; i < 8; i++) begin
      repeat (uart_div_model) @(negedge clk);
      data[i] = o_uart_td;
    end
    repeat (uart_div_model) @(negedge clk);
    if (o_uart_td !== 1'b1) fail_run("uart stop bit was not high at mid bit");
  endtask

  task automatic send_uart(input logic [7:0] data, input logic extra);
    logic [7:0] got;
    logic [7:0] rd;
    fork
      watch_uart_line(got);
      begin
        write_reg(ADDR_UART_DATA, data);
        read_reg(ADDR_STATUS, rd);
        check_status({cur_test, " busy"}, expect_status(1'b1, 1'b0), status_t'(rd));
        // dropped while the frame runs
        if (extra) write_reg(ADDR_UART_DATA, ~data);
      end
    join
    check_byte({cur_test, " uart byte"}, data, got);
    // past the stop bit, no second frame may follow
    repeat (uart_div_model) @(negedge clk);
    read_reg(ADDR_STATUS, rd);
    check_status({cur_test, " idle"}, expect_status(1'b0, 1'b0), status_t'(rd));
  endtask

  // sd card model: miso out after falling sclk, mosi in on rising sclk
  task automatic serve_spi_slave(input logic [7:0] miso, output logic [7:0] got);
    @(negedge clk);
    i_spi_miso = miso[7];
    for (int i = 7; i >= 0; i--) begin
      @(posedge o_spi_sclk);
      @(negedge clk);
      got[i] = o_spi_mosi;
      @(negedge o_spi_sclk);
      if (i > 0) begin
        @(negedge clk);
        i_spi_miso = miso[i-1];
      end
    end
  endtask

  task automatic exchange_spi(input logic [7:0] mosi, input logic [7:0] miso,
                              input logic extra);
    logic [7:0] got;
    logic [7:0] rd;
    status_t    st;
    int         tries;
    fork
      serve_spi_slave(miso, got);
      begin
        write_reg(ADDR_SPI_DATA, mosi);
        read_reg(ADDR_STATUS, rd);
        check_status({cur_test, " busy"}, expect_status(1'b0, 1'b1), status_t'(rd));
        if (extra) write_reg(ADDR_SPI_DATA, ~mosi);
      end
    join
    check_byte({cur_test, " mosi"}, mosi, got);
    // busy drops with the last falling sclk
    tries = 0;
    do begin
      read_reg(ADDR_STATUS, rd);
      st = status_t'(rd);
      tries++;
    end while (st.spi_busy && tries < 4);
    if (st.spi_busy) fail_run("spi busy did not clear after the exchange");
    check_status({cur_test, " idle"}, expect_status(1'b0, 1'b0), st);
    read_reg(ADDR_SPI_DATA, rd);
    check_byte({cur_test, " miso"}, miso, rd);
  endtask

  initial begin
    wait (budget_cycles > 0);
    #(budget_cycles * 4);
    fail_run($sformatf("watchdog expired after %0d cycles, run did not finish",
                       budget_cycles));
  end

  initial begin
    int         idx;
    logic [7:0] op;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] rd;
    logic [7:0] r1;
    logic [7:0] r2;
    i_rst_n        = 1'b0;
    i_req          = '0;
    i_dip_pins     = '0;
    i_sd_detect    = 1'b0;
    i_sd_protect   = 1'b0;
    i_spi_miso     = 1'b0;
    detect_model   = 1'b0;
    protect_model  = 1'b0;
    uart_div_model = UART_DIV_RST;
    lcg_state      = 32'h64218bdf;
    $readmemh("periph_stimulus.txt", stim);
    if ($isunknown(stim[0])) fail_run("stimulus file periph_stimulus.txt could not be read");
    budget_cycles = frame_budget();
    repeat (2) @(negedge clk);
    i_rst_n = 1'b1;
    // pin levels right after reset
    check_level("reset uart td", 1'b1, o_uart_td);
    check_level("reset spi cs_n", 1'b1, o_spi_cs_n);
    check_level("reset spi sclk", 1'b0, o_spi_sclk);
    check_byte("reset led", 8'h00, o_led);
    idx     = 0;
    while (stim[idx][31:24] !== 8'h00) begin
      if (idx >= $size(stim) - 1 || $isunknown(stim[idx])) begin
        fail_run($sformatf("stimulus entry %0d is not a valid word or end is missing", idx));
      end
      {op, a, b, c} = stim[idx];
      cur_test = $sformatf("entry %0d op %02h", idx, op);
      case (op)
        8'h01: begin
          write_reg(a[ADDR_W-1:0], b);
          if (a[ADDR_W-1:0] == ADDR_UART_DIV) uart_div_model = b;
          if (a[ADDR_W-1:0] == ADDR_LED) check_byte({cur_test, " led"}, b, o_led);
          if (a[ADDR_W-1:0] == ADDR_SPI_CTRL) begin
            // chip select pin follows one cycle after the register
            @(negedge clk);
            check_level({cur_test, " cs_n"}, b[7], o_spi_cs_n);
          end
        end
        8'h02: begin
          read_reg(a[ADDR_W-1:0], rd);
          if (a[ADDR_W-1:0] == ADDR_STATUS) begin
            check_status(cur_test, status_t'(b), status_t'(rd));
          end else begin
            check_byte(cur_test, b, rd);
          end
        end
        8'h03: set_pins(a[DIP_W-1:0], b[0], c[0]);
        8'h04: send_uart(a, c[0]);
        8'h05: exchange_spi(a, b, c[0]);
        8'h06: begin
          // random dip value, uart byte or spi byte pair
          if (c == 8'h00) begin
            r1 = next_rand();
            set_pins(r1[DIP_W-1:0], detect_model, protect_model);
            read_reg(ADDR_DIP, rd);
            check_byte({cur_test, " dip"}, {4'h0, r1[DIP_W-1:0]}, rd);
          end else if (c == 8'h01) begin
            send_uart(next_rand(), 1'b0);
          end else begin
            r1 = next_rand();
            r2 = next_rand();
            exchange_spi(r1, r2, 1'b0);
          end
        end
        default: fail_run($sformatf("stimulus entry %0d has unknown op %02h", idx, op));
      endcase
      idx++;
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== periph_stimulus.txt ====
// one hex word per line: op(8) a(8) b(8) c(8)
// 01 write a=addr b=data, 02 read a=addr b=expect, 03 pins a=dip b=detect c=protect
// 04 uart a=byte c=1 extra write while busy, 05 spi a=mosi b=miso c=1 extra write
// 06 random c=0 dip c=1 uart c=2 spi, 00 end of list
02030400 // uart divisor after reset
02058200 // spi ctrl after reset, cs high, div 2
02070000 // unused address reads zero
0100a500 // led write
01003c00 // led write
03090100 // dip 9, card detected
02010900 // dip read back
02062000 // status with detect
03060101 // dip 6, detect and protect
02063000 // status with detect and protect
04550000 // uart frame with divisor 4
01030700 // uart divisor 7
02030700 // divisor read back
04a30001 // uart frame, second write dropped
01050300 // chip select low, spi div 3
05c65b00 // spi exchange
0581e701 // spi exchange, second write dropped
06000000 // random dip
06000001 // random uart byte
06000002 // random spi bytes
01058300 // chip select high
02058300 // ctrl read back
00000000 // end

// ==== list.f ====
soc_pkg.sv
periph_decode.sv
gpio_port.sv
uart_tx.sv
spi_master.sv
periph_top.sv
periph_top_chk.sv
tb_periph_top.sv

// ==== Bender.yml ====
package:
  name: periph_top

sources:
  - soc_pkg.sv
  - periph_decode.sv
  - gpio_port.sv
  - uart_tx.sv
  - spi_master.sv
  - periph_top.sv
  - target: test
    files:
      - periph_top_chk.sv
      - tb_periph_top.sv
